//--- design/clap_pkg.sv
`default_nettype none

package clap_pkg;

    // line buffer states.
    typedef enum logic [1:0] {
        WB_IDLE,
        WB_SEND,
        WB_WAIT_RESP,
        WB_FINISH
    } wb_state_t;

    // address issuer states.
    typedef enum logic {
        AW_IDLE,
        AW_REQ
    } aw_state_t;

    localparam int LINE_WORDS = 16; // words per cache line.
    localparam int WORD_W     = 32;

    // axi encodings.
    localparam logic [1:0] BURST_INCR = 2'd1;
    localparam logic [2:0] SIZE_WORD  = 3'd2;  // 4 bytes per beat.
    localparam logic [1:0] RESP_OKAY  = 2'd0;

endpackage

`default_nettype wire

//--- design/wrt_addr_issue.sv
`timescale 1ns/10ps
`default_nettype none

module wrt_addr_issue #(
    parameter int ADDR_W = 32
) (
    input  logic              clk,
    input  logic              rstn,
    input  logic              w_buf_we,
    input  logic [ADDR_W-1:0] wrt_addr,
    input  logic              uncache,
    input  logic              awready,
    output logic [ADDR_W-1:0] awaddr,
    output logic [7:0]        awlen,
    output logic [2:0]        awsize,
    output logic [1:0]        awburst,
    output logic              awvalid
);
    import clap_pkg::*;

    aw_state_t         state;
    logic [ADDR_W-1:0] addr_q;
    logic [7:0]        len_q;

    // word aligned for a single store, line aligned otherwise.
    always_ff @(posedge clk) begin
        if (w_buf_we) begin
            if (uncache) begin
                addr_q <= {wrt_addr[ADDR_W-1:2], 2'b00};
                len_q  <= 8'd0;
            end else begin
                addr_q <= {wrt_addr[ADDR_W-1:6], 6'b0};
                len_q  <= 8'(LINE_WORDS-1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= AW_IDLE;
        end else begin
            case (state)
                AW_IDLE: begin
                    if (w_buf_we) state <= AW_REQ;
                end
                AW_REQ: begin
                    if (awready) state <= AW_IDLE; // handshake done.
                end
                default: state <= AW_IDLE;
            endcase
        end
    end

    assign awvalid = (state == AW_REQ);
    assign awaddr  = addr_q;
    assign awlen   = len_q;
    assign awsize  = SIZE_WORD;
    assign awburst = BURST_INCR;

    // request stays up, unchanged, until the slave accepts it.
    a_aw_hold: assert property (
        @(posedge clk) disable iff (!rstn)
        (awvalid && !awready) |=> (awvalid && $stable(awaddr) && $stable(awlen))
    );

endmodule

`default_nettype wire

//--- design/wrt_axi_top.sv
`timescale 1ns/10ps
`default_nettype none

module wrt_axi_top #(
    parameter int ADDR_W = 32
) (
    input  logic                                             clk,
    input  logic                                             rstn,
    // cache side.
    input  logic                                             w_buf_we,
    input  logic [clap_pkg::LINE_WORDS*clap_pkg::WORD_W-1:0] w_line_mem,
    input  logic [ADDR_W-1:0]                                wrt_addr,
    input  logic                                             uncache,
    input  logic                                             wrt_reset,
    output logic                                             wrt_busy,
    output logic                                             wrt_finish,
    output logic                                             wrt_error,
    // axi write address.
    output logic [ADDR_W-1:0]                                awaddr,
    output logic [7:0]                                       awlen,
    output logic [2:0]                                       awsize,
    output logic [1:0]                                       awburst,
    output logic                                             awvalid,
    input  logic                                             awready,
    // axi write data.
    output logic [clap_pkg::WORD_W-1:0]                      wdata,
    output logic                                             wvalid,
    output logic                                             wlast,
    input  logic                                             wready,
    // axi write response.
    input  logic [1:0]                                       bresp,
    input  logic                                             bvalid,
    output logic                                             bready
);

    logic [3:0] word_offset;

    assign word_offset = wrt_addr[5:2]; // word within the line.

    wrt_addr_issue #(
        .ADDR_W (ADDR_W)
    ) i_wrt_addr_issue (
        .clk      (clk),
        .rstn     (rstn),
        .w_buf_we (w_buf_we),
        .wrt_addr (wrt_addr),
        .uncache  (uncache),
        .awready  (awready),
        .awaddr   (awaddr),
        .awlen    (awlen),
        .awsize   (awsize),
        .awburst  (awburst),
        .awvalid  (awvalid)
    );

    // buffer starts the data phase on the same aw handshake.
    wrt_line_buffer i_wrt_line_buffer (
        .clk         (clk),
        .rstn        (rstn),
        .w_buf_we    (w_buf_we),
        .w_line_mem  (w_line_mem),
        .uncache     (uncache),
        .word_offset (word_offset),
        .awvalid     (awvalid),
        .awready     (awready),
        .wready      (wready),
        .bvalid      (bvalid),
        .bresp       (bresp),
        .wrt_reset   (wrt_reset),
        .wdata       (wdata),
        .wvalid      (wvalid),
        .wlast       (wlast),
        .bready      (bready),
        .wrt_finish  (wrt_finish),
        .wrt_error   (wrt_error),
        .wrt_busy    (wrt_busy)
    );

endmodule

`default_nettype wire

//--- design/wrt_line_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module wrt_line_buffer (
    input  logic                                             clk,
    input  logic                                             rstn,
    input  logic                                             w_buf_we,
    input  logic [clap_pkg::LINE_WORDS*clap_pkg::WORD_W-1:0] w_line_mem,
    input  logic                                             uncache,
    input  logic [3:0]                                       word_offset,
    input  logic                                             awvalid,
    input  logic                                             awready,
    input  logic                                             wready,
    input  logic                                             bvalid,
    input  logic [1:0]                                       bresp,
    input  logic                                             wrt_reset,
    output logic [clap_pkg::WORD_W-1:0]                      wdata,
    output logic                                             wvalid,
    output logic                                             wlast,
    output logic                                             bready,
    output logic                                             wrt_finish,
    output logic                                             wrt_error,
    output logic                                             wrt_busy
);
    import clap_pkg::*;

    wb_state_t                         state;
    wb_state_t                         state_nxt;
    logic [LINE_WORDS*WORD_W-1:0]      line_q;
    logic                              uncache_q;
    logic [3:0]                        beat;
    logic                              err_q;
    logic                              busy_q;
    logic                              aw_fire;
    logic                              w_fire;

    assign aw_fire = awvalid && awready;
    assign w_fire  = wvalid && wready;

    // line and mode, captured on the load strobe.
    always_ff @(posedge clk) begin
        if (w_buf_we) begin
            line_q    <= w_line_mem;
            uncache_q <= uncache;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= WB_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            WB_IDLE: begin
                if (aw_fire) state_nxt = WB_SEND; // burst accepted.
            end
            WB_SEND: begin
                if (w_fire && wlast) state_nxt = WB_WAIT_RESP;
            end
            WB_WAIT_RESP: begin
                if (bvalid) state_nxt = WB_FINISH;
            end
            WB_FINISH: begin
                if (wrt_reset) state_nxt = WB_IDLE;
            end
            default: state_nxt = WB_IDLE;
        endcase
    end

    // beat index, starts at the store's word for uncached writes.
    always_ff @(posedge clk) begin
        if (!rstn) begin
            beat <= 4'd0;
        end else if (w_buf_we) begin
            beat <= uncache ? word_offset : 4'd0;
        end else if (state == WB_SEND && w_fire) begin
            beat <= beat + 4'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            err_q <= 1'b0;
        end else if (state == WB_WAIT_RESP && bvalid) begin
            err_q <= (bresp != RESP_OKAY);
        end else if (state == WB_FINISH && wrt_reset) begin
            err_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            busy_q <= 1'b0;
        end else if (w_buf_we) begin
            busy_q <= 1'b1;
        end else if (state == WB_FINISH && wrt_reset) begin
            busy_q <= 1'b0; // cache has taken the result.
        end
    end

    assign wdata      = line_q[beat*WORD_W +: WORD_W];
    assign wvalid     = (state == WB_SEND);
    assign wlast      = (state == WB_SEND) && (uncache_q || beat == 4'(LINE_WORDS-1));
    assign bready     = (state == WB_WAIT_RESP);
    assign wrt_finish = (state == WB_FINISH);
    assign wrt_error  = err_q;
    assign wrt_busy   = busy_q;

    // data beat must hold until the slave takes it.
    a_w_stable: assert property (
        @(posedge clk) disable iff (!rstn)
        (wvalid && !wready) |=> (wvalid && $stable(wdata))
    );

    // cache may load a new line only once the previous one is acknowledged.
    a_no_load_busy: assert property (
        @(posedge clk) disable iff (!rstn)
        w_buf_we |-> !wrt_busy
    );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps -Mdir obj_dir \
    --top-module tb_wrt_axi_top -f wrt_axi_top.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_wrt_axi_top)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Result: PASSED" <<< "$sim_out"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

//--- verification/tb_wrt_axi_top.sv
`timescale 1ns/10ps
`default_nettype none

module tb_wrt_axi_top;
    import clap_pkg::*;

    localparam int BURST_TIMEOUT = 400; // cycles per burst.

    logic                         clk = 1'b0;
    logic                         rstn;
    logic                         w_buf_we;
    logic [LINE_WORDS*WORD_W-1:0] w_line_mem;
    logic [31:0]                  wrt_addr;
    logic                         uncache;
    logic                         wrt_reset;
    logic                         wrt_busy;
    logic                         wrt_finish;
    logic                         wrt_error;
    logic [31:0]                  awaddr;
    logic [7:0]                   awlen;
    logic [2:0]                   awsize;
    logic [1:0]                   awburst;
    logic                         awvalid;
    logic                         awready;
    logic [WORD_W-1:0]            wdata;
    logic                         wvalid;
    logic                         wlast;
    logic                         wready;
    logic [1:0]                   bresp;
    logic                         bvalid;
    logic                         bready;

    logic [31:0]       lfsr = 32'h09ed_4c5a;
    logic [WORD_W-1:0] beats[$];      // data beats seen by the slave.
    logic              last_flags[$];
    int                aw_count;
    logic [31:0]       cap_awaddr;
    logic [7:0]        cap_awlen;
    logic [2:0]        cap_awsize;
    logic [1:0]        cap_awburst;
    int                test_errs;
    int                tests_passed;
    int                tests_failed;

    wrt_axi_top i_wrt_axi_top (.*);

    initial begin
        forever #2 clk = ~clk;
    end

    // fibonacci lfsr with taps 32 22 2 1.
    function automatic logic lfsr_step_bit();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [LINE_WORDS*WORD_W-1:0] random_line();
        logic [LINE_WORDS*WORD_W-1:0] l;
        for (int i = 0; i < LINE_WORDS*WORD_W; i++) begin
            l = {l[LINE_WORDS*WORD_W-2:0], lfsr_step_bit()};
        end
        return l;
    endfunction

    task automatic report_mismatch(input string name, input string what,
                                   input logic [31:0] exp, input logic [31:0] act);
        $display("Fail %s: %s expected %h actual %h", name, what, exp, act);
        test_errs++;
    endtask

    task automatic load_line(input logic [LINE_WORDS*WORD_W-1:0] line,
                             input logic [31:0] addr, input logic unc);
        @(negedge clk);
        w_buf_we = 1'b1;
        w_line_mem = line;
        wrt_addr = addr;
        uncache = unc;
        @(negedge clk);
        w_buf_we = 1'b0;
    endtask

    // slave answers one burst on each falling edge until wrt_finish.
    task automatic serve_burst(input string name, input logic stall, input logic [1:0] resp);
        int   cycles;
        logic resp_due;
        logic b_taken;
        cycles = 0;
        resp_due = 1'b0;
        b_taken = 1'b0;
        aw_count = 0;
        beats.delete();
        last_flags.delete();
        while (!wrt_finish && cycles < BURST_TIMEOUT) begin
            @(negedge clk);
            cycles++;
            if (resp_due && !bvalid) begin // response one cycle after wlast.
                bvalid = 1'b1;
                bresp = resp;
            end
            awready = stall ? lfsr_step_bit() : 1'b1;
            wready = stall ? lfsr_step_bit() : 1'b1;
            if (awvalid && awready) begin
                aw_count++;
                cap_awaddr = awaddr;
                cap_awlen = awlen;
                cap_awsize = awsize;
                cap_awburst = awburst;
            end
            if (wvalid && wready) begin
                beats.push_back(wdata);
                last_flags.push_back(wlast);
                resp_due = resp_due | wlast;
            end
            if (bvalid && bready) b_taken = 1'b1;
        end
        bvalid = 1'b0;
        awready = 1'b0;
        wready = 1'b0;
        if (!wrt_finish) begin
            $display("test %s: wrt_finish did not rise within %0d cycles", name, BURST_TIMEOUT);
            test_errs++;
        end else if (!b_taken) begin
            $display("test %s: write response finished without bready high", name);
            test_errs++;
        end
    endtask

    task automatic run_write(input string name, input logic [LINE_WORDS*WORD_W-1:0] line,
                             input logic [31:0] addr, input logic unc, input logic stall,
                             input logic [1:0] resp);
        int          n;
        int          first;
        logic [31:0] exp_addr;
        n = unc ? 1 : LINE_WORDS;
        first = unc ? int'(addr % 64) / 4 : 0; // word offset within the line.
        exp_addr = unc ? (addr & ~32'h3) : (addr & ~32'h3f);
        load_line(line, addr, unc);
        if (wrt_busy !== 1'b1) report_mismatch(name, "wrt_busy", 1, 32'(wrt_busy));
        serve_burst(name, stall, resp);
        if (aw_count != 1) report_mismatch(name, "aw transfers", 1, aw_count);
        if (cap_awaddr !== exp_addr) report_mismatch(name, "awaddr", exp_addr, cap_awaddr);
        if (cap_awlen !== 8'(n - 1)) report_mismatch(name, "awlen", n - 1, 32'(cap_awlen));
        if (cap_awsize !== 3'd2) report_mismatch(name, "awsize", 2, 32'(cap_awsize));
        if (cap_awburst !== 2'd1) report_mismatch(name, "awburst", 1, 32'(cap_awburst));
        if (beats.size() != n) report_mismatch(name, "beat count", n, beats.size());
        for (int i = 0; i < n && i < beats.size(); i++) begin
            if (beats[i] !== line[(first + i)*WORD_W +: WORD_W])
                report_mismatch(name, $sformatf("beat %0d", i),
                                line[(first + i)*WORD_W +: WORD_W], beats[i]);
            if (last_flags[i] !== (i == n - 1))
                report_mismatch(name, $sformatf("wlast beat %0d", i),
                                32'(i == n - 1), 32'(last_flags[i]));
        end
    endtask

    task automatic ack_finish(input string name);
        @(negedge clk);
        wrt_reset = 1'b1;
        @(negedge clk);
        wrt_reset = 1'b0;
        if (wrt_finish !== 1'b0) report_mismatch(name, "wrt_finish after ack", 0, 32'(wrt_finish));
        if (wrt_busy !== 1'b0) report_mismatch(name, "wrt_busy after ack", 0, 32'(wrt_busy));
    endtask

    task automatic close_test(input string name);
        if (test_errs == 0) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, test_errs);
        end
        test_errs = 0;
    endtask

    task automatic test_reset_state();
        repeat (5) @(negedge clk);
        if ({awvalid, wvalid, wlast, bready, wrt_finish, wrt_busy, wrt_error} !== 7'b0)
            report_mismatch("reset_state", "{awv,wv,wlast,bready,finish,busy,error}", 0,
                            32'({awvalid, wvalid, wlast, bready, wrt_finish, wrt_busy, wrt_error}));
        close_test("reset_state");
    endtask

    task automatic test_full_line(input string name, input logic stall);
        run_write(name, random_line(), stall ? 32'h7fff_f0d4 : 32'h0004_13a8, 1'b0, stall, 2'd0);
        if (wrt_error !== 1'b0) report_mismatch(name, "wrt_error", 0, 32'(wrt_error));
        ack_finish(name);
        close_test(name);
    endtask

    task automatic test_uncached_store();
        run_write("uncached_store", random_line(), 32'h8000_1a27, 1'b1, 1'b0, 2'd0); // word 9.
        if (wrt_error !== 1'b0) report_mismatch("uncached_store", "wrt_error", 0, 32'(wrt_error));
        ack_finish("uncached_store");
        close_test("uncached_store");
    endtask

    task automatic test_error_response();
        run_write("error_response", random_line(), 32'h0010_0040, 1'b0, 1'b0, 2'd2);
        if (wrt_error !== 1'b1) report_mismatch("error_response", "wrt_error", 1, 32'(wrt_error));
        ack_finish("error_response");
        // next burst must come back clean.
        run_write("error_response", random_line(), 32'h0010_0a8c, 1'b0, 1'b1, 2'd0);
        if (wrt_error !== 1'b0) report_mismatch("error_response", "wrt_error", 0, 32'(wrt_error));
        ack_finish("error_response");
        close_test("error_response");
    endtask

    initial begin
        rstn = 1'b0;
        w_buf_we = 1'b0;
        w_line_mem = '0;
        wrt_addr = '0;
        uncache = 1'b0;
        wrt_reset = 1'b0;
        awready = 1'b0;
        wready = 1'b0;
        bvalid = 1'b0;
        bresp = 2'd0;
        test_errs = 0;
        tests_passed = 0;
        tests_failed = 0;
        repeat (2) @(negedge clk);
        rstn = 1'b1;
        test_reset_state();
        test_full_line("full_line", 1'b0);
        test_full_line("back_pressure", 1'b1);
        test_uncached_store();
        test_error_response();
        $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- wrt_axi_top.f
design/clap_pkg.sv
design/wrt_line_buffer.sv
design/wrt_addr_issue.sv
design/wrt_axi_top.sv
verification/tb_wrt_axi_top.sv
